/* files.f */
rtl/core_pkg.sv
rtl/isa_pkg.sv
rtl/pipe_if.sv
rtl/stage_fetch.sv
rtl/stage_decode.sv
rtl/stage_execute.sv
rtl/stage_memory.sv
rtl/core.sv
sim/core_checker.sv
sim/tb_core.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_core -f files.f -o tb_core_sim

# The log decides the result, so a stopped run still reaches the search
./obj_dir/tb_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    exit 0
else
    exit 1
fi

/* sim/tb_core.sv */
`default_nettype none

module tb_core;
    import core_pkg::*;
    import isa_pkg::*;

    // Program is a data window clear, register seeds, a random body and EBREAK
    localparam int DATA_WORDS   = 8;
    localparam int SEED_REGS    = 6;
    localparam int RANDOM_COUNT = 48;
    localparam int USED_REGS    = 10;
    localparam int HALT_INDEX   = DATA_WORDS + SEED_REGS + RANDOM_COUNT;
    localparam int DONE_LIMIT   = 5000;
    localparam logic [2:0]      F3_WORD     = 3'b010;
    localparam logic [XLEN-1:0] EBREAK_WORD = 32'h0010_0073;

    logic                   clk;
    logic                   rst;
    logic                   run;
    logic                   imem_we;
    logic [IMEM_ADDR_W-1:0] imem_addr;
    logic [XLEN-1:0]        imem_wdata;
    logic [REG_ADDR_W-1:0]  debug_addr;
    logic [XLEN-1:0]        debug_data;
    logic                   wb_valid;
    logic [REG_ADDR_W-1:0]  wb_rd;
    logic [XLEN-1:0]        wb_data;
    logic                   halted;

    logic [XLEN-1:0] prog [IMEM_DEPTH];
    int              prog_len;
    int              last1;
    int              last2;
    integer          seed;
    logic            start;
    logic            done;
    int              errors;
    int              retires;

    core uut (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .debug_addr (debug_addr),
        .debug_data (debug_data),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .halted     (halted)
    );

    core_checker u_checker (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .program_words (prog),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .halted        (halted),
        .debug_data    (debug_data),
        .debug_addr    (debug_addr),
        .errors        (errors),
        .retires       (retires),
        .done          (done)
    );

    always #2 clk = ~clk;

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    // Source register that is clear of the two previous destinations
    function automatic logic [4:0] pick_source();
        int r;
        r = rand_below(USED_REGS);
        while (r == last1 || r == last2) begin
            r = (r + 1) % USED_REGS;
        end
        return 5'(r);
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    // Append one word and note its destination (-1 for none)
    task automatic emit(input logic [31:0] word, input int dest);
        prog[IMEM_ADDR_W'(prog_len)] = word;
        prog_len = prog_len + 1;
        last2    = last1;
        last1    = dest;
    endtask

    task automatic build_program();
        int         k;
        int         kind;
        int         off;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        for (k = 0; k < IMEM_DEPTH; k++) begin
            prog[IMEM_ADDR_W'(k)] = '0;
        end
        prog_len = 0;
        last1    = -1;
        last2    = -1;
        // Data memory has no reset, so clear the window loads can reach
        for (k = 0; k < DATA_WORDS; k++) begin
            emit(s_type(12'(4 * k), 5'd0, 5'd0), -1);
        end
        for (k = 1; k <= SEED_REGS; k++) begin
            emit(i_type(12'(rand_below(4096)), 5'd0, F3_ADD_SUB, 5'(k), OP_IMM), k);
        end
        for (k = 0; k < RANDOM_COUNT; k++) begin
            kind = rand_below(10);
            rd   = 5'(rand_below(USED_REGS));
            rs1  = pick_source();
            rs2  = pick_source();
            f7   = 7'b0;
            if (kind < 4) begin
                case (rand_below(6))
                    0:       f3 = F3_ADD_SUB;
                    1: begin
                        f3 = F3_ADD_SUB;
                        f7 = F7_SUB;
                    end
                    2:       f3 = F3_AND;
                    3:       f3 = F3_OR;
                    4:       f3 = F3_XOR;
                    default: f3 = F3_SLT;
                endcase
                emit(r_type(f7, rs2, rs1, f3, rd), int'(rd));
            end else if (kind < 6) begin
                emit(i_type(12'(rand_below(4096)), rs1, F3_ADD_SUB, rd, OP_IMM), int'(rd));
            end else if (kind == 6) begin
                emit(i_type(12'(4 * rand_below(DATA_WORDS)), 5'd0, F3_WORD, rd, OP_LOAD),
                     int'(rd));
            end else if (kind == 7) begin
                emit(s_type(12'(4 * rand_below(DATA_WORDS)), rs2, 5'd0), -1);
            end else begin
                // Equal operands half the time, so both outcomes show up
                if (rand_below(2) == 0) begin
                    rs2 = rs1;
                end
                off = 1 + rand_below(4);
                if (prog_len + off > HALT_INDEX) begin
                    off = HALT_INDEX - prog_len;
                end
                f3 = (kind == 8) ? F3_BEQ : F3_BNE;
                emit(b_type(13'(4 * off), rs2, rs1, f3), -1);
            end
        end
        emit(EBREAK_WORD, -1);
    endtask

    task automatic load_program();
        int k;
        for (k = 0; k < prog_len; k++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= IMEM_ADDR_W'(k);
            imem_wdata <= prog[IMEM_ADDR_W'(k)];
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    initial begin
        int wait_cycles;
        clk        = 1'b0;
        rst        = 1'b1;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        start      = 1'b0;
        seed       = 14;
        build_program();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        load_program();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        run <= 1'b1;
        wait_cycles = 0;
        while (!done && wait_cycles < DONE_LIMIT) begin
            @(posedge clk);
            wait_cycles = wait_cycles + 1;
        end
        if (!done) begin
            $display("Timeout: checker did not finish within %0d cycles", DONE_LIMIT);
            $display("Done: errors found");
        end else begin
            $display("Retires: %0d, errors: %0d", retires, errors);
            if (errors == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/core_checker.sv */
`default_nettype none

module core_checker (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  logic [core_pkg::XLEN-1:0]       program_words [core_pkg::IMEM_DEPTH],
    input  logic                            wb_valid,
    input  logic [core_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic [core_pkg::XLEN-1:0]       wb_data,
    input  logic                            halted,
    input  logic [core_pkg::XLEN-1:0]       debug_data,
    output logic [core_pkg::REG_ADDR_W-1:0] debug_addr,
    output int                              errors,
    output int                              retires,
    output logic                            done
);
    import core_pkg::*;
    import isa_pkg::*;

    localparam int START_LIMIT = 1000;
    localparam int HALT_LIMIT  = 2000;
    localparam int STEP_LIMIT  = 256;

    logic [XLEN-1:0]       model_regs [REG_COUNT];
    logic [XLEN-1:0]       model_dmem [DMEM_DEPTH];
    logic [REG_ADDR_W-1:0] exp_rd [$];
    logic [XLEN-1:0]       exp_data [$];
    int                    retire_errors = 0;
    int                    state_errors  = 0;
    int                    retire_count  = 0;

    assign errors  = retire_errors + state_errors;
    assign retires = retire_count;

    // Instruction-level model that fills the list of expected register writes
    task automatic run_model();
        logic [XLEN-1:0] word;
        instr_u          w;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_s;
        logic [XLEN-1:0] imm_b;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] res;
        logic            writes;
        logic            stop;
        int              pc;
        int              next_pc;
        int              steps;
        int              i;
        for (i = 0; i < REG_COUNT; i++) begin
            model_regs[REG_ADDR_W'(i)] = '0;
        end
        for (i = 0; i < DMEM_DEPTH; i++) begin
            model_dmem[DMEM_ADDR_W'(i)] = '0;
        end
        pc    = 0;
        steps = 0;
        stop  = 1'b0;
        while (!stop && steps < STEP_LIMIT && pc < IMEM_DEPTH) begin
            word    = program_words[IMEM_ADDR_W'(pc)];
            w       = word;
            a       = model_regs[w.r.rs1];
            b       = model_regs[w.r.rs2];
            imm_i   = {{20{word[31]}}, word[31:20]};
            imm_s   = {{20{word[31]}}, word[31:25], word[11:7]};
            imm_b   = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
            res     = '0;
            writes  = 1'b0;
            next_pc = pc + 1;
            case (w.r.opcode)
                OP_REG: begin
                    writes = 1'b1;
                    case (w.r.funct3)
                        F3_ADD_SUB: res = (w.r.funct7 == F7_SUB) ? a - b : a + b;
                        F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        F3_XOR:     res = a ^ b;
                        F3_OR:      res = a | b;
                        F3_AND:     res = a & b;
                        default:    writes = 1'b0;
                    endcase
                end
                OP_IMM: begin
                    writes = 1'b1;
                    res    = a + imm_i;
                end
                OP_LOAD: begin
                    writes = 1'b1;
                    addr   = a + imm_i;
                    res    = model_dmem[addr[DMEM_ADDR_W+1:2]];
                end
                OP_STORE: begin
                    addr = a + imm_s;
                    model_dmem[addr[DMEM_ADDR_W+1:2]] = b;
                end
                OP_BRANCH: begin
                    // BNE takes on a difference, BEQ on equality
                    if ((w.sb.funct3 == F3_BNE) ? (a != b) : (a == b)) begin
                        next_pc = pc + int'($signed(imm_b)) / 4;
                    end
                end
                OP_SYSTEM: stop = 1'b1;
                default: ;
            endcase
            if (writes && w.r.rd != '0) begin
                model_regs[w.r.rd] = res;
                exp_rd.push_back(w.r.rd);
                exp_data.push_back(res);
            end
            pc    = next_pc;
            steps = steps + 1;
        end
        if (!stop) begin
            $display("Model did not reach EBREAK within %0d steps", STEP_LIMIT);
            state_errors = state_errors + 1;
        end
    endtask

    // Retires are compared at the falling edge
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            if (halted) begin
                $display("Retire of x%0d at time %0t came after halt", wb_rd, $time);
                retire_errors = retire_errors + 1;
            end
            if (retire_count >= exp_rd.size()) begin
                $display("Unexpected retire of x%0d at time %0t, model has no write left",
                         wb_rd, $time);
                retire_errors = retire_errors + 1;
            end else begin
                if (wb_rd !== exp_rd[retire_count]) begin
                    $display("FAIL t=%0t wb_rd: got %0d, expected %0d",
                             $time, wb_rd, exp_rd[retire_count]);
                    retire_errors = retire_errors + 1;
                end
                if (wb_data !== exp_data[retire_count]) begin
                    $display("FAIL t=%0t wb_data: got %h, expected %h",
                             $time, wb_data, exp_data[retire_count]);
                    retire_errors = retire_errors + 1;
                end
            end
            retire_count = retire_count + 1;
        end
    end

    initial begin
        int wait_cycles;
        int a;
        done        = 1'b0;
        debug_addr  = '0;
        wait_cycles = 0;
        while (!start && wait_cycles < START_LIMIT) begin
            @(posedge clk);
            wait_cycles = wait_cycles + 1;
        end
        if (!start) begin
            $display("Program was never handed to the checker");
            state_errors = state_errors + 1;
        end else begin
            run_model();
            wait_cycles = 0;
            while (!halted && wait_cycles < HALT_LIMIT) begin
                @(negedge clk);
                wait_cycles = wait_cycles + 1;
            end
            if (!halted) begin
                $display("halted did not rise within %0d cycles of the start", HALT_LIMIT);
                state_errors = state_errors + 1;
            end else begin
                // Debug port answers one cycle after the address
                for (a = 0; a < REG_COUNT; a++) begin
                    @(posedge clk);
                    debug_addr <= REG_ADDR_W'(a);
                    @(posedge clk);
                    @(negedge clk);
                    if (debug_data !== model_regs[REG_ADDR_W'(a)]) begin
                        $display("FAIL t=%0t debug_data x%0d: got %h, expected %h",
                                 $time, a, debug_data, model_regs[REG_ADDR_W'(a)]);
                        state_errors = state_errors + 1;
                    end
                end
            end
            if (retire_count != exp_rd.size()) begin
                $display("Core retired %0d register writes, model expects %0d",
                         retire_count, exp_rd.size());
                state_errors = state_errors + 1;
            end
        end
        done = 1'b1;
    end

endmodule

`default_nettype wire

/* rtl/core.sv */
`default_nettype none

module core (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            run,
    input  logic                            imem_we,
    input  logic [core_pkg::IMEM_ADDR_W-1:0] imem_addr,
    input  logic [core_pkg::XLEN-1:0]       imem_wdata,
    input  logic [core_pkg::REG_ADDR_W-1:0] debug_addr,
    output logic [core_pkg::XLEN-1:0]       debug_data,
    output logic                            wb_valid,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [core_pkg::XLEN-1:0]       wb_data,
    output logic                            halted
);
    import core_pkg::*;

    // IF/ID and the halt feedback
    logic            if_valid;
    logic [XLEN-1:0] if_pc;
    logic [XLEN-1:0] if_instr;
    logic            stop_fetch;

    idex_if  idex ();
    exmem_if exmem ();
    memwb_if memwb ();

    stage_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .stop_fetch (stop_fetch),
        .ex         (exmem),
        .if_valid   (if_valid),
        .if_pc      (if_pc),
        .if_instr   (if_instr)
    );

    // Also holds the register file and the writeback select
    stage_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .if_valid   (if_valid),
        .if_pc      (if_pc),
        .if_instr   (if_instr),
        .ex         (exmem),
        .wb         (memwb),
        .id         (idex),
        .stop_fetch (stop_fetch),
        .debug_addr (debug_addr),
        .debug_data (debug_data),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    stage_execute u_execute (
        .clk (clk),
        .rst (rst),
        .id  (idex),
        .ex  (exmem)
    );

    stage_memory u_memory (
        .clk    (clk),
        .rst    (rst),
        .ex     (exmem),
        .wb     (memwb),
        .halted (halted)
    );

endmodule

`default_nettype wire

/* rtl/stage_memory.sv */
`default_nettype none

module stage_memory (
    input  logic     clk,
    input  logic     rst,
    exmem_if.memory  ex,
    memwb_if.source  wb,
    output logic     halted
);
    import core_pkg::*;

    logic [XLEN-1:0]        dmem [DMEM_DEPTH];
    logic [DMEM_ADDR_W-1:0] word_idx;
    logic                   halt_seen;

    assign word_idx = ex.alu_out[DMEM_ADDR_W+1:2];

    // Stores from valid entries only
    always_ff @(posedge clk) begin
        if (ex.valid && ex.mem_write) begin
            dmem[word_idx] <= ex.store_data;
        end
    end

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb.rd         <= ex.rd;
        wb.reg_write  <= ex.reg_write;
        wb.mem_to_reg <= ex.mem_read;
        wb.alu_out    <= ex.alu_out;
        wb.load_data  <= dmem[word_idx];
        wb.halt       <= ex.halt;
    end

    // halted rises as the EBREAK sits in MEM/WB and sticks
    always_ff @(posedge clk) begin
        if (rst) begin
            halt_seen <= 1'b0;
        end else if (wb.valid && wb.halt) begin
            halt_seen <= 1'b1;
        end
    end

    assign halted = halt_seen || (wb.valid && wb.halt);

    a_no_read_and_write: assert property (
        @(posedge clk) disable iff (rst) ex.valid |-> !(ex.mem_read && ex.mem_write)
    );

endmodule

`default_nettype wire

/* rtl/stage_execute.sv */
`default_nettype none

module stage_execute (
    input  logic     clk,
    input  logic     rst,
    idex_if.sink     id,
    exmem_if.source  ex
);
    import core_pkg::*;
    import isa_pkg::*;

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    logic            operands_eq;
    logic            taken;
    logic            live;

    assign op_b = id.alu_src ? id.imm : id.rs2_data;

    always_comb begin
        case (id.alu_op)
            ALU_ADD: alu_out = id.rs1_data + op_b;
            ALU_SUB: alu_out = id.rs1_data - op_b;
            ALU_AND: alu_out = id.rs1_data & op_b;
            ALU_OR:  alu_out = id.rs1_data | op_b;
            ALU_XOR: alu_out = id.rs1_data ^ op_b;
            ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, $signed(id.rs1_data) < $signed(op_b)};
            default: alu_out = '0;
        endcase
    end

    // BEQ when branch_ne is low, BNE otherwise
    assign operands_eq = (id.rs1_data == id.rs2_data);
    assign taken       = id.branch && (operands_eq ^ id.branch_ne);

    // The entry behind a taken branch is the first of the three squashed
    assign live = id.valid && !ex.branch_taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex.valid        <= 1'b0;
            ex.branch_taken <= 1'b0;
        end else begin
            ex.valid        <= live;
            ex.branch_taken <= live && taken;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        ex.alu_out       <= alu_out;
        ex.store_data    <= id.rs2_data;
        ex.rd            <= id.rd;
        ex.mem_read      <= id.mem_read;
        ex.mem_write     <= id.mem_write;
        ex.reg_write     <= id.reg_write;
        ex.halt          <= id.halt;
        ex.branch_target <= id.pc + id.imm;
    end

    // A taken branch is a live entry that writes nothing
    a_taken_is_valid: assert property (
        @(posedge clk) disable iff (rst)
            ex.branch_taken |-> (ex.valid && !ex.reg_write && !ex.mem_write)
    );

endmodule

`default_nettype wire

/* rtl/stage_decode.sv */
`default_nettype none

module stage_decode (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             if_valid,
    input  logic [core_pkg::XLEN-1:0]        if_pc,
    input  logic [core_pkg::XLEN-1:0]        if_instr,
    exmem_if.squash                          ex,
    memwb_if.sink                            wb,
    idex_if.source                           id,
    output logic                             stop_fetch,
    input  logic [core_pkg::REG_ADDR_W-1:0]  debug_addr,
    output logic [core_pkg::XLEN-1:0]        debug_data,
    output logic                             wb_valid,
    output logic [core_pkg::REG_ADDR_W-1:0]  wb_rd,
    output logic [core_pkg::XLEN-1:0]        wb_data
);
    import core_pkg::*;
    import isa_pkg::*;

    logic [XLEN-1:0]     regs [REG_COUNT];
    instr_u              insn;
    logic [XLEN-1:0]     imm_i;
    logic [XLEN-1:0]     imm_s;
    logic [XLEN-1:0]     imm_b;
    logic [XLEN-1:0]     imm;
    logic [XLEN-1:0]     rs1_data;
    logic [XLEN-1:0]     rs2_data;
    logic [ALU_OP_W-1:0] alu_op;
    logic                alu_src;
    logic                mem_read;
    logic                mem_write;
    logic                branch;
    logic                reg_write;
    logic                halt;
    logic                halt_decoded;
    logic                halt_seen;

    assign insn  = if_instr;
    assign imm_i = {{20{insn.r.funct7[6]}}, insn.r.funct7, insn.r.rs2};
    assign imm_s = {{20{insn.sb.imm_hi[6]}}, insn.sb.imm_hi, insn.sb.imm_lo};
    assign imm_b = {{20{insn.sb.imm_hi[6]}}, insn.sb.imm_lo[0], insn.sb.imm_hi[5:0],
                    insn.sb.imm_lo[4:1], 1'b0};

    // Control decode
    always_comb begin
        imm       = '0;
        alu_op    = ALU_ADD;
        alu_src   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        reg_write = 1'b0;
        halt      = 1'b0;
        case (insn.r.opcode)
            OP_REG: begin
                reg_write = 1'b1;
                case (insn.r.funct3)
                    F3_ADD_SUB: alu_op = (insn.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    alu_op = ALU_ADD;
                endcase
            end
            OP_IMM: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                imm       = imm_i;
            end
            OP_LOAD: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                alu_src   = 1'b1;
                imm       = imm_i;
            end
            OP_STORE: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm       = imm_s;
            end
            OP_BRANCH: begin
                branch = (insn.sb.funct3 == F3_BEQ) || (insn.sb.funct3 == F3_BNE);
                imm    = imm_b;
            end
            OP_SYSTEM: halt = 1'b1;
            default: ;
        endcase
    end

    // Writeback select and register write
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.mem_to_reg ? wb.load_data : wb.alu_out;
    assign wb_valid = wb.valid && wb.reg_write && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Reads see the write of the same cycle
    assign rs1_data = (insn.r.rs1 == '0) ? '0 :
                      (wb_valid && wb_rd == insn.r.rs1) ? wb_data : regs[insn.r.rs1];
    assign rs2_data = (insn.r.rs2 == '0) ? '0 :
                      (wb_valid && wb_rd == insn.r.rs2) ? wb_data : regs[insn.r.rs2];

    always_ff @(posedge clk) begin
        debug_data <= (debug_addr == '0) ? '0 : regs[debug_addr];
    end

    // Halt stops fetch at once unless a squashing branch cancels it
    assign halt_decoded = if_valid && halt && !ex.branch_taken;
    assign stop_fetch   = halt_seen || halt_decoded;

    always_ff @(posedge clk) begin
        if (rst || ex.branch_taken) begin
            halt_seen <= 1'b0;
        end else if (halt_decoded) begin
            halt_seen <= 1'b1;
        end
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        if (rst) begin
            id.valid <= 1'b0;
        end else begin
            id.valid <= if_valid && !ex.branch_taken;
        end
    end

    always_ff @(posedge clk) begin
        id.pc        <= if_pc;
        id.rs1_data  <= rs1_data;
        id.rs2_data  <= rs2_data;
        id.imm       <= imm;
        id.rd        <= insn.r.rd;
        id.alu_op    <= alu_op;
        id.alu_src   <= alu_src;
        id.mem_read  <= mem_read;
        id.mem_write <= mem_write;
        id.branch    <= branch;
        id.branch_ne <= (insn.sb.funct3 == F3_BNE);
        id.reg_write <= reg_write;
        id.halt      <= halt;
    end

    // No new fetch follows a decoded EBREAK unless a branch redirects
    a_halt_stops_fetch: assert property (
        @(posedge clk) disable iff (rst) (stop_fetch && !ex.branch_taken) |=> !if_valid
    );

endmodule

`default_nettype wire

/* rtl/stage_fetch.sv */
`default_nettype none

module stage_fetch (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          run,
    input  logic                          imem_we,
    input  logic [core_pkg::IMEM_ADDR_W-1:0] imem_addr,
    input  logic [core_pkg::XLEN-1:0]     imem_wdata,
    input  logic                          stop_fetch,
    exmem_if.fetch                        ex,
    output logic                          if_valid,
    output logic [core_pkg::XLEN-1:0]     if_pc,
    output logic [core_pkg::XLEN-1:0]     if_instr
);
    import core_pkg::*;

    logic [XLEN-1:0]        imem [IMEM_DEPTH];
    logic [XLEN-1:0]        pc;
    logic [IMEM_ADDR_W-1:0] pc_word;

    // Word index of the current PC
    assign pc_word = pc[IMEM_ADDR_W+1:2];

    // Load port, used only while the core is stopped
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    // PC and IF/ID valid
    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (ex.branch_taken) begin
            // Redirect wins; the word read this cycle is on the wrong path
            pc       <= ex.branch_target;
            if_valid <= 1'b0;
        end else if (run && !stop_fetch) begin
            pc       <= pc + XLEN'(4);
            if_valid <= 1'b1;
        end else begin
            if_valid <= 1'b0;
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        if_pc    <= pc;
        if_instr <= imem[pc_word];
    end

    a_no_load_while_running: assert property (
        @(posedge clk) disable iff (rst) run |-> !imem_we
    );

endmodule

`default_nettype wire

/* rtl/pipe_if.sv */
`default_nettype none

// Decode to execute bundle
interface idex_if;
    import core_pkg::*;
    import isa_pkg::*;

    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rd;
    logic [ALU_OP_W-1:0]   alu_op;
    logic                  alu_src;
    logic                  mem_read;
    logic                  mem_write;
    logic                  branch;
    logic                  branch_ne;
    logic                  reg_write;
    logic                  halt;

    modport source (output valid, pc, rs1_data, rs2_data, imm, rd, alu_op, alu_src,
                    mem_read, mem_write, branch, branch_ne, reg_write, halt);
    modport sink   (input valid, pc, rs1_data, rs2_data, imm, rd, alu_op, alu_src,
                    mem_read, mem_write, branch, branch_ne, reg_write, halt);
endinterface

// Execute to memory bundle that also carries the branch redirect for fetch and decode
interface exmem_if;
    import core_pkg::*;

    logic                  valid;
    logic [XLEN-1:0]       alu_out;
    logic [XLEN-1:0]       store_data;
    logic [REG_ADDR_W-1:0] rd;
    logic                  mem_read;
    logic                  mem_write;
    logic                  reg_write;
    logic                  halt;
    logic                  branch_taken;
    logic [XLEN-1:0]       branch_target;

    modport source (output valid, alu_out, store_data, rd, mem_read, mem_write, reg_write,
                    halt, branch_taken, branch_target);
    modport memory (input valid, alu_out, store_data, rd, mem_read, mem_write, reg_write,
                    halt);
    modport fetch  (input branch_taken, branch_target);
    modport squash (input branch_taken);
endinterface

// Memory to writeback bundle
interface memwb_if;
    import core_pkg::*;

    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_write;
    logic                  mem_to_reg;
    logic [XLEN-1:0]       alu_out;
    logic [XLEN-1:0]       load_data;
    logic                  halt;

    modport source (output valid, rd, reg_write, mem_to_reg, alu_out, load_data, halt);
    modport sink   (input valid, rd, reg_write, mem_to_reg, alu_out, load_data);
endinterface

`default_nettype wire

/* rtl/isa_pkg.sv */
`default_nettype none

// Encodings of the supported RV32I subset
package isa_pkg;

    // Major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // Function codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    // Internal ALU operation codes
    localparam int ALU_OP_W = 3;
    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd5;

    // Register view that also serves I-type with imm in funct7 and rs2
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_reg_t;

    // Store and branch view with split immediate
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_sb_t;

    typedef union packed {
        instr_reg_t r;
        instr_sb_t  sb;
    } instr_u;

endpackage

`default_nettype wire

/* rtl/core_pkg.sv */
`default_nettype none

// Machine sizes and memory depths shared by the whole core
package core_pkg;

    // Data path and address width
    localparam int XLEN = 32;

    // Architectural register file
    localparam int REG_COUNT  = 32;
    localparam int REG_ADDR_W = 5;

    // Word-addressed instruction memory
    localparam int IMEM_DEPTH  = 64;
    localparam int IMEM_ADDR_W = 6;

    // Word-addressed data memory
    localparam int DMEM_DEPTH  = 64;
    localparam int DMEM_ADDR_W = 6;

endpackage

`default_nettype wire
